// File: bench/tb_clkgen.sv
// ====================
// testbench clock and reset
// 10 ns clock, reset held low for 10 cycles on start or request
// ====================
`default_nettype none

module tb_clkgen (
	input  logic i_rst_req,
	output logic o_clk,
	output logic o_nrst
);
	timeunit 1ns;
	timeprecision 1ps;

	int cnt;

	initial begin
		o_clk = 1'b0;
		forever #5 o_clk = ~o_clk;
	end

	// cycles of reset still to go
	initial cnt = 10;

	always @(posedge o_clk) begin
		if (i_rst_req) begin
			cnt <= 10;
		end else if (cnt != 0) begin
			cnt <= cnt - 1;
		end
	end

	assign o_nrst = (cnt == 0);

endmodule

`default_nettype wire

// File: bench/tb_fetch_subsys.sv
// ====================
// fetch subsystem testbench
// loads programs over the host port and checks the fetched stream
// ====================
`default_nettype none

`include "core_params.svh"

module tb_fetch_subsys;
	timeunit 1ns;
	timeprecision 1ps;

	localparam int TIMEOUT = 64;

	// one program word and the register side values seen while it is handed over
	typedef struct packed {
		int          set;
		logic [31:0] addr;
		logic [31:0] instr;
		logic        cmp_eq;
		logic [31:0] jr_addr;
	} row_t;

	// one run of a program
	typedef struct packed {
		int   set;
		int   steps;
		logic stall;
		logic host;
	} run_t;

	logic clk;
	logic nrst;
	logic rst_req;
	logic run;
	logic host_valid;
	logic host_ready;
	bus_pkg::mem_req_t host_req;
	logic host_rsp_valid;
	bus_pkg::mem_rsp_t host_rsp;
	logic out_valid;
	logic out_ready;
	core_pkg::fetch_out_t out;
	logic cmp_eq;
	logic [`CORE_XLEN-1:0] jr_addr;

	row_t rows[$];
	run_t runs[$];
	logic [31:0] rng;
	int checks;
	int errors;
	int timeouts;

	tb_clkgen clkgen0 (
		.i_rst_req (rst_req),
		.o_clk     (clk),
		.o_nrst    (nrst)
	);

	fetch_subsys dut0 (
		.i_clk            (clk),
		.i_nrst           (nrst),
		.i_run            (run),
		.i_host_valid     (host_valid),
		.o_host_ready     (host_ready),
		.i_host_req       (host_req),
		.o_host_rsp_valid (host_rsp_valid),
		.o_host_rsp       (host_rsp),
		.o_out_valid      (out_valid),
		.i_out_ready      (out_ready),
		.o_out            (out),
		.i_cmp_eq         (cmp_eq),
		.i_jr_addr        (jr_addr)
	);

	// ====================
	// helpers
	// ====================
	function automatic logic [31:0] xorshift(input logic [31:0] x);
		logic [31:0] y;
		y = x ^ (x << 13);
		y = y ^ (y >> 17);
		y = y ^ (y << 5);
		return y;
	endfunction

	function automatic logic [31:0] enc_r(input logic [4:0] rd, input logic [5:0] funct);
		return {6'h00, 5'd4, 5'd5, rd, 5'd0, funct};
	endfunction

	function automatic logic [31:0] enc_i(input logic [5:0] op, input logic [15:0] imm);
		return {op, 5'd1, 5'd2, imm};
	endfunction

	function automatic logic [31:0] enc_j(input logic [5:0] op, input logic [31:0] dest);
		return {op, dest[27:2]};
	endfunction

	// host test pattern, every address bit matters
	function automatic logic [31:0] fill_word(input logic [31:0] addr);
		return {~addr[15:0], addr[15:0]} ^ {addr[31:16], addr[31:16]} ^ 32'h3C3C_A5A5;
	endfunction

	// reference next pc from the instruction fields
	function automatic logic [31:0] ref_next_pc(input logic [31:0] pc, input logic [31:0] instr,
			input logic eq, input logic [31:0] jr);
		logic [31:0] pc4;
		logic [5:0] op;
		logic [31:0] offs;
		pc4 = pc + 32'd4;
		op = instr[31:26];
		offs = {{14{instr[15]}}, instr[15:0], 2'b00};
		if ((op == 6'h02) || (op == 6'h03)) begin
			return {pc4[31:28], instr[25:0], 2'b00};
		end else if ((op == 6'h00) && (instr[5:0] == 6'h08)) begin
			return jr;
		end else if (((op == 6'h04) && eq) || ((op == 6'h05) && !eq)) begin
			return pc4 + offs;
		end
		return pc4;
	endfunction

	function automatic int find_row(input int set, input logic [31:0] addr);
		foreach (rows[i]) begin
			if ((rows[i].set == set) && (rows[i].addr == addr)) begin
				return i;
			end
		end
		return -1;
	endfunction

	task automatic add_row(input int set, input logic [31:0] addr, input logic [31:0] instr,
			input logic eq, input logic [31:0] jr);
		row_t r;
		r.set = set;
		r.addr = addr;
		r.instr = instr;
		r.cmp_eq = eq;
		r.jr_addr = jr;
		rows.push_back(r);
	endtask

	task automatic add_run(input int set, input int steps, input logic stall, input logic host);
		run_t r;
		r.set = set;
		r.steps = steps;
		r.stall = stall;
		r.host = host;
		runs.push_back(r);
	endtask

	task automatic compare_word(input string name, input logic [31:0] got, input logic [31:0] exp);
		checks++;
		if (got !== exp) begin
			errors++;
			$display("Fail %s: got %h, expected %h", name, got, exp);
		end
	endtask

	// ====================
	// stimulus table
	// ====================
	task automatic build_tables();
		// set 0, straight line then back to the start
		add_row(0, 32'h00, enc_r(5'd1, 6'h20), 1'b0, 32'h0);
		add_row(0, 32'h04, enc_r(5'd2, 6'h20), 1'b0, 32'h0);
		add_row(0, 32'h08, enc_r(5'd3, 6'h20), 1'b0, 32'h0);
		add_row(0, 32'h0C, enc_r(5'd4, 6'h20), 1'b0, 32'h0);
		add_row(0, 32'h10, enc_r(5'd5, 6'h20), 1'b0, 32'h0);
		add_row(0, 32'h14, enc_j(6'h02, 32'h00), 1'b0, 32'h0);
		// set 1, j, jal and jr
		add_row(1, 32'h00, enc_j(6'h02, 32'h40), 1'b0, 32'h300);
		add_row(1, 32'h40, enc_j(6'h03, 32'h80), 1'b1, 32'h0);
		add_row(1, 32'h80, enc_r(5'd6, 6'h20), 1'b1, 32'h0);
		add_row(1, 32'h84, enc_r(5'd0, 6'h08), 1'b0, 32'h100);
		add_row(1, 32'h100, enc_r(5'd7, 6'h20), 1'b0, 32'h0);
		add_row(1, 32'h104, enc_j(6'h02, 32'h00), 1'b0, 32'h0);
		// set 2, beq and bne both ways, two backward offsets
		add_row(2, 32'h00, enc_i(6'h04, 16'h0003), 1'b1, 32'h0);
		add_row(2, 32'h10, enc_i(6'h04, 16'h0005), 1'b0, 32'h0);
		add_row(2, 32'h14, enc_i(6'h05, 16'h0002), 1'b1, 32'h0);
		add_row(2, 32'h18, enc_i(6'h05, 16'hFFFA), 1'b0, 32'h0);
		add_row(2, 32'h04, enc_r(5'd1, 6'h20), 1'b1, 32'h0);
		add_row(2, 32'h08, enc_i(6'h04, 16'hFFFD), 1'b1, 32'h0);
		// set, steps, random back-pressure, host reads alongside
		add_run(0, 12, 1'b0, 1'b0);
		add_run(1, 12, 1'b0, 1'b0);
		add_run(2, 14, 1'b0, 1'b0);
		add_run(2, 20, 1'b1, 1'b0);
		add_run(1, 16, 1'b1, 1'b1);
	endtask

	// ====================
	// bus tasks
	// ====================
	task automatic wait_reset_release();
		int t;
		t = 0;
		while (!nrst && (t < TIMEOUT)) begin
			@(negedge clk);
			t++;
		end
		if (!nrst) begin
			errors++;
			timeouts++;
			$display("reset was never released");
		end
	endtask

	task automatic pulse_reset();
		@(negedge clk);
		rst_req = 1'b1;
		@(negedge clk);
		rst_req = 1'b0;
		wait_reset_release();
	endtask

	// one host transfer and its response, idle means fetch must stay silent
	task automatic host_access(input logic wr, input logic [31:0] addr, input logic [31:0] wdata,
			input logic idle, output logic [31:0] rdata);
		int t;
		rdata = '0;
		@(negedge clk);
		host_valid = 1'b1;
		host_req.wr = wr;
		host_req.addr = addr;
		host_req.wdata = wdata;
		#1;
		t = 0;
		while (!host_ready && (t < TIMEOUT)) begin
			@(negedge clk);
			#1;
			t++;
		end
		if (!host_ready) begin
			errors++;
			timeouts++;
			$display("host request to %h was never accepted", addr);
			host_valid = 1'b0;
			return;
		end
		@(negedge clk);
		host_valid = 1'b0;
		#1;
		t = 0;
		while (!host_rsp_valid && (t < TIMEOUT)) begin
			@(negedge clk);
			#1;
			t++;
		end
		if (!host_rsp_valid) begin
			errors++;
			timeouts++;
			$display("host response for %h never arrived", addr);
			return;
		end
		if (idle && dut0.f_rsp_valid) begin
			errors++;
			$display("Fail f_rsp_valid: got %h, expected %h", 1'b1, 1'b0);
		end
		rdata = host_rsp.rdata;
	endtask

	task automatic load_program(input int set);
		logic [31:0] rd;
		foreach (rows[i]) begin
			if (rows[i].set == set) begin
				host_access(1'b1, rows[i].addr, rows[i].instr, 1'b0, rd);
			end
		end
	endtask

	task automatic host_readback(input int set, input int passes);
		logic [31:0] rd;
		for (int p = 0; p < passes; p++) begin
			foreach (rows[i]) begin
				if (rows[i].set == set) begin
					host_access(1'b0, rows[i].addr, 32'h0, 1'b0, rd);
					compare_word("o_host_rsp.rdata", rd, rows[i].instr);
				end
			end
		end
	endtask

	// ====================
	// fetch stream
	// ====================
	task automatic run_stream(input int set, input int steps, input logic stall);
		logic [31:0] ref_pc;
		logic ready_now;
		int done;
		int idle;
		int idx;
		ref_pc = `CORE_RESET_PC;
		done = 0;
		idle = 0;
		while ((done < steps) && (idle < TIMEOUT)) begin
			@(negedge clk);
			rng = xorshift(rng);
			ready_now = stall ? (rng[1:0] != 2'b00) : 1'b1;
			idle++;
			if (out_valid) begin
				idx = find_row(set, ref_pc);
				if (idx < 0) begin
					errors++;
					$display("expected pc %h lies outside the program", ref_pc);
					break;
				end
				compare_word("o_out.pc", out.pc, ref_pc);
				compare_word("o_out.pc4", out.pc4, ref_pc + 32'd4);
				compare_word("o_out.instr", out.instr, rows[idx].instr);
				cmp_eq = rows[idx].cmp_eq;
				jr_addr = rows[idx].jr_addr;
				// handshake on the next rising edge
				if (ready_now) begin
					ref_pc = ref_next_pc(ref_pc, rows[idx].instr, rows[idx].cmp_eq,
						rows[idx].jr_addr);
					done++;
					idle = 0;
				end
			end
			out_ready = ready_now;
		end
		if (done < steps) begin
			errors++;
			timeouts++;
			$display("fetch stream stopped after %0d of %0d instructions", done, steps);
		end
		@(negedge clk);
		out_ready = 1'b0;
	endtask

	// ====================
	// main sequence
	// ====================
	initial begin
		logic [31:0] addr;
		logic [31:0] rd;
		rst_req = 1'b0;
		run = 1'b0;
		host_valid = 1'b0;
		host_req = '0;
		out_ready = 1'b0;
		cmp_eq = 1'b0;
		jr_addr = '0;
		rng = 32'd7;
		checks = 0;
		errors = 0;
		timeouts = 0;
		build_tables();
		// reset generator is running by the first falling edge
		@(negedge clk);
		wait_reset_release();

		// host writes then reads, fetch idle
		for (int i = 0; i < 8; i++) begin
			addr = 32'h200 + 32'(i) * 32'd4;
			host_access(1'b1, addr, fill_word(addr), 1'b1, rd);
		end
		for (int i = 0; i < 8; i++) begin
			addr = 32'h200 + 32'(i) * 32'd4;
			host_access(1'b0, addr, 32'h0, 1'b1, rd);
			compare_word("o_host_rsp.rdata", rd, fill_word(addr));
		end

		foreach (runs[r]) begin
			load_program(runs[r].set);
			pulse_reset();
			@(negedge clk);
			run = 1'b1;
			if (runs[r].host) begin
				fork
					run_stream(runs[r].set, runs[r].steps, runs[r].stall);
					host_readback(runs[r].set, 2);
				join
			end else begin
				run_stream(runs[r].set, runs[r].steps, runs[r].stall);
			end
			run = 1'b0;
		end

		$display("checks %0d, errors %0d, timeouts %0d", checks, errors, timeouts);
		if (errors == 0) begin
			$display("All tests passed!");
		end else begin
			$display("Test failures found");
		end
		$finish;
	end

endmodule

`default_nettype wire

// File: hw/branch_resolver.sv
// ====================
// branch resolver
// picks the next pc from the instruction being handed over
// ====================
`default_nettype none

`include "core_params.svh"

module branch_resolver (
	input  core_pkg::fetch_out_t  i_out,
	input  logic                  i_cmp_eq,
	input  logic [`CORE_XLEN-1:0] i_jr_addr,
	output logic [`CORE_XLEN-1:0] o_next_pc
);

	// ====================
	// decode
	// ====================
	core_pkg::instr_u ins;
	logic [`CORE_XLEN-1:0] j_target;
	logic [`CORE_XLEN-1:0] b_offset;
	logic [`CORE_XLEN-1:0] b_target;
	logic is_jr;
	logic b_taken;

	assign ins = i_out.instr;

	// region of pc+4 joined with the word target
	assign j_target = {i_out.pc4[`CORE_XLEN-1:`CORE_XLEN-4], ins.j.target, 2'b00};

	// sign extended word offset, relative to pc+4
	assign b_offset = {{(`CORE_XLEN-18){ins.i.imm[15]}}, ins.i.imm, 2'b00};
	assign b_target = i_out.pc4 + b_offset;

	assign is_jr = (ins.r.opcode == core_pkg::OP_RTYPE) &&
		(ins.r.funct == core_pkg::FUNCT_JR);

	// beq on equal, bne on not equal
	assign b_taken = ((ins.i.opcode == core_pkg::OP_BEQ) && i_cmp_eq) ||
		((ins.i.opcode == core_pkg::OP_BNE) && !i_cmp_eq);

	// ====================
	// next pc select
	// ====================
	always_comb begin
		o_next_pc = i_out.pc4;
		if ((ins.j.opcode == core_pkg::OP_J) || (ins.j.opcode == core_pkg::OP_JAL)) begin
			o_next_pc = j_target;
		end else if (is_jr) begin
			o_next_pc = i_jr_addr;
		end else if (b_taken) begin
			o_next_pc = b_target;
		end
	end

endmodule

`default_nettype wire

// File: hw/bus_pkg.sv
// ====================
// memory bus types
// request and response payloads shared by the arbiter and its peers
// ====================
`default_nettype none

`include "core_params.svh"

package bus_pkg;

	// ====================
	// request
	// ====================
	// byte address, word aligned
	// wr set means a write of wdata, clear means a read
	typedef struct packed {
		logic                  wr;
		logic [`CORE_XLEN-1:0] addr;
		logic [`CORE_XLEN-1:0] wdata;
	} mem_req_t;

	// ====================
	// response
	// ====================
	// read data, valid one cycle after the grant
	typedef struct packed {
		logic [`CORE_XLEN-1:0] rdata;
	} mem_rsp_t;

endpackage

`default_nettype wire

// File: hw/core_pkg.sv
// ====================
// core types
// opcodes, instruction formats and the fetch output payload
// ====================
`default_nettype none

`include "core_params.svh"

package core_pkg;

	// ====================
	// opcodes
	// ====================
	typedef enum logic [5:0] {
		OP_RTYPE = 6'h00,
		OP_J     = 6'h02,
		OP_JAL   = 6'h03,
		OP_BEQ   = 6'h04,
		OP_BNE   = 6'h05
	} opcode_e;

	// function field of jr
	localparam logic [5:0] FUNCT_JR = 6'h08;

	// ====================
	// formats
	// ====================
	typedef struct packed {
		opcode_e    opcode;
		logic [4:0] rs;
		logic [4:0] rt;
		logic [4:0] rd;
		logic [4:0] shamt;
		logic [5:0] funct;
	} r_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [4:0]  rs;
		logic [4:0]  rt;
		logic [15:0] imm;
	} i_fmt_t;

	typedef struct packed {
		opcode_e     opcode;
		logic [25:0] target;
	} j_fmt_t;

	// one word, three views
	typedef union packed {
		r_fmt_t r;
		i_fmt_t i;
		j_fmt_t j;
	} instr_u;

	// handed downstream by the fetch unit
	typedef struct packed {
		logic [`CORE_XLEN-1:0] pc;
		logic [`CORE_XLEN-1:0] pc4;
		instr_u                instr;
	} fetch_out_t;

endpackage

`default_nettype wire

// File: hw/fetch_subsys.sv
// ====================
// fetch subsystem
// fetch, resolver, arbiter and shared memory
// ====================
`default_nettype none

`include "core_params.svh"

module fetch_subsys (
	input  logic                  i_clk,
	input  logic                  i_nrst,
	input  logic                  i_run,
	// host port
	input  logic                  i_host_valid,
	output logic                  o_host_ready,
	input  bus_pkg::mem_req_t     i_host_req,
	output logic                  o_host_rsp_valid,
	output bus_pkg::mem_rsp_t     o_host_rsp,
	// instruction stream
	output logic                  o_out_valid,
	input  logic                  i_out_ready,
	output core_pkg::fetch_out_t  o_out,
	// register side inputs
	input  logic                  i_cmp_eq,
	input  logic [`CORE_XLEN-1:0] i_jr_addr
);

	// ====================
	// wires
	// ====================
	logic f_req_valid;
	logic f_req_ready;
	bus_pkg::mem_req_t f_req;
	logic f_rsp_valid;
	bus_pkg::mem_rsp_t f_rsp;
	logic [`CORE_XLEN-1:0] next_pc;
	logic ram_en;
	bus_pkg::mem_req_t ram_req;
	bus_pkg::mem_rsp_t ram_rsp;

	// ====================
	// hierarchy
	// ====================
	fetch_unit u_fetch (
		.i_clk       (i_clk),
		.i_nrst      (i_nrst),
		.i_run       (i_run),
		.o_req_valid (f_req_valid),
		.i_req_ready (f_req_ready),
		.o_req       (f_req),
		.i_rsp_valid (f_rsp_valid),
		.i_rsp       (f_rsp),
		.o_out_valid (o_out_valid),
		.i_out_ready (i_out_ready),
		.o_out       (o_out),
		.i_next_pc   (next_pc)
	);

	// reads the held output payload
	branch_resolver u_resolver (
		.i_out     (o_out),
		.i_cmp_eq  (i_cmp_eq),
		.i_jr_addr (i_jr_addr),
		.o_next_pc (next_pc)
	);

	mem_arbiter u_arbiter (
		.i_clk         (i_clk),
		.i_nrst        (i_nrst),
		.i_f_valid     (f_req_valid),
		.o_f_ready     (f_req_ready),
		.i_f_req       (f_req),
		.o_f_rsp_valid (f_rsp_valid),
		.o_f_rsp       (f_rsp),
		.i_h_valid     (i_host_valid),
		.o_h_ready     (o_host_ready),
		.i_h_req       (i_host_req),
		.o_h_rsp_valid (o_host_rsp_valid),
		.o_h_rsp       (o_host_rsp),
		.o_ram_en      (ram_en),
		.o_ram_req     (ram_req),
		.i_ram_rsp     (ram_rsp)
	);

	shared_ram u_ram (
		.i_clk  (i_clk),
		.i_nrst (i_nrst),
		.i_en   (ram_en),
		.i_req  (ram_req),
		.o_rsp  (ram_rsp)
	);

endmodule

`default_nettype wire

// File: hw/fetch_unit.sv
// ====================
// fetch unit
// pc register, one fetch in flight, registered output stage
// ====================
`default_nettype none

`include "core_params.svh"

module fetch_unit (
	input  logic                  i_clk,
	input  logic                  i_nrst,
	input  logic                  i_run,
	// memory request
	output logic                  o_req_valid,
	input  logic                  i_req_ready,
	output bus_pkg::mem_req_t     o_req,
	// memory response
	input  logic                  i_rsp_valid,
	input  bus_pkg::mem_rsp_t     i_rsp,
	// instruction out
	output logic                  o_out_valid,
	input  logic                  i_out_ready,
	output core_pkg::fetch_out_t  o_out,
	// from the resolver
	input  logic [`CORE_XLEN-1:0] i_next_pc
);

	typedef enum logic [1:0] {
		S_REQ,
		S_WAIT,
		S_HOLD
	} state_e;

	// ====================
	// registers
	// ====================
	state_e state_q;
	logic run_q;
	logic [`CORE_XLEN-1:0] pc_q;
	logic [`CORE_XLEN-1:0] pc4;
	core_pkg::fetch_out_t out_q;

	assign pc4 = pc_q + `CORE_XLEN'd4;

	// control
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			state_q <= S_REQ;
			run_q   <= 1'b0;
			pc_q    <= `CORE_RESET_PC;
		end else begin
			// run is sticky once seen
			if (i_run) begin
				run_q <= 1'b1;
			end
			case (state_q)
				S_REQ: begin
					if (o_req_valid && i_req_ready) begin
						state_q <= S_WAIT;
					end
				end
				S_WAIT: begin
					if (i_rsp_valid) begin
						state_q <= S_HOLD;
					end
				end
				S_HOLD: begin
					// handshake, step to the resolved pc
					if (i_out_ready) begin
						state_q <= S_REQ;
						pc_q    <= i_next_pc;
					end
				end
				default: state_q <= S_REQ;
			endcase
		end
	end

	// pipe register, pc and pc+4 travel with the word
	always_ff @(posedge i_clk) begin
		if ((state_q == S_WAIT) && i_rsp_valid) begin
			out_q.pc    <= pc_q;
			out_q.pc4   <= pc4;
			out_q.instr <= i_rsp.rdata;
		end
	end

	// ====================
	// outputs
	// ====================
	assign o_req_valid = (state_q == S_REQ) && run_q;
	assign o_req.wr    = 1'b0;
	assign o_req.addr  = pc_q;
	assign o_req.wdata = '0;

	assign o_out_valid = (state_q == S_HOLD);
	assign o_out       = out_q;

endmodule

`default_nettype wire

// File: hw/mem_arbiter.sv
// ====================
// memory arbiter
// round-robin between fetch and host, responses routed by owner id
// ====================
`default_nettype none

module mem_arbiter (
	input  logic              i_clk,
	input  logic              i_nrst,
	// fetch port
	input  logic              i_f_valid,
	output logic              o_f_ready,
	input  bus_pkg::mem_req_t i_f_req,
	output logic              o_f_rsp_valid,
	output bus_pkg::mem_rsp_t o_f_rsp,
	// host port
	input  logic              i_h_valid,
	output logic              o_h_ready,
	input  bus_pkg::mem_req_t i_h_req,
	output logic              o_h_rsp_valid,
	output bus_pkg::mem_rsp_t o_h_rsp,
	// ram side
	output logic              o_ram_en,
	output bus_pkg::mem_req_t o_ram_req,
	input  bus_pkg::mem_rsp_t i_ram_rsp
);

	// ====================
	// state
	// ====================
	// ptr set gives the host priority
	logic ptr_q;
	logic pending_q;
	// owner of the access in flight, set for host
	logic owner_q;
	logic f_grant;
	logic h_grant;

	// ====================
	// grant
	// ====================
	// at most one ready when both are valid
	assign o_f_ready = !pending_q && !(i_h_valid && ptr_q);
	assign o_h_ready = !pending_q && !(i_f_valid && !ptr_q);

	assign f_grant = i_f_valid && o_f_ready;
	assign h_grant = i_h_valid && o_h_ready;

	assign o_ram_en  = f_grant || h_grant;
	assign o_ram_req = f_grant ? i_f_req : i_h_req;

	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			ptr_q     <= 1'b0;
			pending_q <= 1'b0;
			owner_q   <= 1'b0;
		end else begin
			// response always comes back the next cycle
			pending_q <= f_grant || h_grant;
			if (f_grant || h_grant) begin
				// favour the other side next time
				ptr_q   <= f_grant;
				owner_q <= h_grant;
			end
		end
	end

	// ====================
	// response routing
	// ====================
	assign o_f_rsp_valid = pending_q && !owner_q;
	assign o_h_rsp_valid = pending_q && owner_q;

	assign o_f_rsp = o_f_rsp_valid ? i_ram_rsp : '0;
	assign o_h_rsp = o_h_rsp_valid ? i_ram_rsp : '0;

endmodule

`default_nettype wire

// File: hw/shared_ram.sv
// ====================
// shared word memory
// single port, one cycle read latency
// ====================
`default_nettype none

`include "core_params.svh"

module shared_ram (
	input  logic              i_clk,
	input  logic              i_nrst,
	input  logic              i_en,
	input  bus_pkg::mem_req_t i_req,
	output bus_pkg::mem_rsp_t o_rsp
);

	// ====================
	// storage
	// ====================
	logic [`CORE_XLEN-1:0] mem [`CORE_MEM_DEPTH];
	logic [`CORE_MEM_AW-1:0] idx;
	logic [`CORE_XLEN-1:0] rdata_q;

	// word index from the byte address
	assign idx = i_req.addr[`CORE_MEM_AW+1:2];

	// write port
	always_ff @(posedge i_clk) begin
		if (i_en && i_req.wr) begin
			mem[idx] <= i_req.wdata;
		end
	end

	// registered read, old data on a write
	always_ff @(posedge i_clk, negedge i_nrst) begin
		if (!i_nrst) begin
			rdata_q <= '0;
		end else if (i_en) begin
			rdata_q <= mem[idx];
		end
	end

	assign o_rsp.rdata = rdata_q;

endmodule

`default_nettype wire

// File: include/core_params.svh
// ====================
// core parameters
// widths, memory size and reset vector for the fetch subsystem
// ====================
`ifndef CORE_PARAMS_SVH
`define CORE_PARAMS_SVH

// ====================
// datapath
// ====================
// data and address width
`define CORE_XLEN 32

// ====================
// memory
// ====================
// word address bits, 256 words
`define CORE_MEM_AW 8
`define CORE_MEM_DEPTH (1 << `CORE_MEM_AW)

// ====================
// program counter
// ====================
// first fetch address after reset
`define CORE_RESET_PC 32'h0000_0000

`endif

// File: project.f
+incdir+include
hw/bus_pkg.sv
hw/core_pkg.sv
hw/shared_ram.sv
hw/mem_arbiter.sv
hw/branch_resolver.sv
hw/fetch_unit.sv
hw/fetch_subsys.sv
bench/tb_clkgen.sv
bench/tb_fetch_subsys.sv

// File: run.sh
#!/bin/sh
# build and run the fetch subsystem testbench with Verilator
set -e
cd "$(dirname "$0")"

verilator --binary --timing --timescale 1ns/1ps \
	-f project.f \
	--top-module tb_fetch_subsys \
	-o sim_fetch

out="$(./obj_dir/sim_fetch)"
echo "$out"

# the grep status decides the script status
echo "$out" | grep -q "All tests passed!"
